//--- bench/map_stimulus.txt
# columns: op a b c d idx exp (decimal)
# wall/brick/iron: a=x b=y; up/eup: a..d = l r t b; shot/eshot: a=x b=y c=tick
wall 31 200 0 0 0 1
wall 608 200 0 0 0 1
wall 32 32 0 0 0 0
wall 607 447 0 0 0 0
wall 320 31 0 0 0 1
wall 320 448 0 0 0 1
brick 32 96 0 0 20 1
brick 47 111 0 0 20 1
brick 48 96 0 0 20 0
brick 32 112 0 0 20 0
brick 48 96 0 0 21 1
brick 290 434 0 0 0 1
brick 320 368 0 0 9 1
brick 383 415 0 0 19 1
brick 512 96 0 0 50 1
brick 368 160 0 0 51 1
iron 288 256 0 0 3 1
iron 319 287 0 0 3 1
iron 320 256 0 0 3 0
iron 288 288 0 0 3 0
up 32 63 113 144 20 1
up 72 103 113 144 20 0
up 32 63 114 145 20 0
up 128 159 289 320 100 1
eup 32 63 113 144 20 1
eup 72 103 113 144 20 0
shot 36 100 1 0 0 1
brick 40 104 0 0 20 0
shot 36 100 1 0 0 0
up 32 63 113 144 20 0
eup 32 63 113 144 20 0
eshot 140 270 1 0 0 1
iron 140 270 0 0 0 1
shot 52 100 0 0 0 0
brick 52 100 0 0 21 1
eshot 52 100 1 0 0 1
brick 52 100 0 0 21 0

//--- map_tile.f
hw/map_pkg.sv
hw/brick_state.sv
hw/bullet_collide.sv
hw/block_stop.sv
hw/pixel_map.sv
hw/map_top.sv
bench/map_chk.sv
bench/map_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the playfield testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module map_tb -Mdir obj_dir -f map_tile.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

# Keep running after an assertion error so the testbench can report
sim_output=$(./obj_dir/Vmap_tb +verilator+error+limit+1000)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^All tests passed$" <<< "$sim_output"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi

//--- bench/map_tb.sv
`timescale 1ns/100ps

module map_tb
    import map_pkg::*;
();

    localparam int NUM_BRICK  = 100;
    localparam int MAX_CYCLES = 2000;

    localparam logic [63:0] OP_WALL  = "wall";
    localparam logic [63:0] OP_BRICK = "brick";
    localparam logic [63:0] OP_IRON  = "iron";
    localparam logic [63:0] OP_UP    = "up";
    localparam logic [63:0] OP_EUP   = "eup";
    localparam logic [63:0] OP_SHOT  = "shot";
    localparam logic [63:0] OP_ESHOT = "eshot";

    logic   clk_50MHz;
    logic   reset;
    coord_t x;
    coord_t y;
    logic   refresh_tick;
    coord_t tank_l;
    coord_t tank_r;
    coord_t tank_t;
    coord_t tank_b;
    coord_t enemy_l;
    coord_t enemy_r;
    coord_t enemy_t;
    coord_t enemy_b;
    coord_t bullet_x;
    coord_t bullet_y;
    coord_t enemy_bullet_x;
    coord_t enemy_bullet_y;

    logic                          hit;
    logic                          enemy_hit;
    logic [NUM_BRICK+NUM_IRON-1:0] stop_up;
    logic [NUM_BRICK+NUM_IRON-1:0] stop_down;
    logic [NUM_BRICK+NUM_IRON-1:0] stop_left;
    logic [NUM_BRICK+NUM_IRON-1:0] stop_right;
    logic [NUM_BRICK+NUM_IRON-1:0] enemy_stop_up;
    logic [NUM_BRICK+NUM_IRON-1:0] enemy_stop_down;
    logic [NUM_BRICK+NUM_IRON-1:0] enemy_stop_left;
    logic [NUM_BRICK+NUM_IRON-1:0] enemy_stop_right;
    logic [NUM_BRICK-1:0]          brick_on;
    logic [NUM_IRON-1:0]           iron_on;
    logic                          wall_on;

    int cycles = 0;
    int tests = 0;
    int errors = 0;

    map_top #(
        .num_brick         (NUM_BRICK),
        .player_bullet_size(4)
    ) dut (
        .clk_50MHz       (clk_50MHz),
        .reset           (reset),
        .x               (x),
        .y               (y),
        .refresh_tick    (refresh_tick),
        .tank_l          (tank_l),
        .tank_r          (tank_r),
        .tank_t          (tank_t),
        .tank_b          (tank_b),
        .enemy_l         (enemy_l),
        .enemy_r         (enemy_r),
        .enemy_t         (enemy_t),
        .enemy_b         (enemy_b),
        .bullet_x        (bullet_x),
        .bullet_y        (bullet_y),
        .enemy_bullet_x  (enemy_bullet_x),
        .enemy_bullet_y  (enemy_bullet_y),
        .hit             (hit),
        .enemy_hit       (enemy_hit),
        .stop_up         (stop_up),
        .stop_down       (stop_down),
        .stop_left       (stop_left),
        .stop_right      (stop_right),
        .enemy_stop_up   (enemy_stop_up),
        .enemy_stop_down (enemy_stop_down),
        .enemy_stop_left (enemy_stop_left),
        .enemy_stop_right(enemy_stop_right),
        .brick_on        (brick_on),
        .iron_on         (iron_on),
        .wall_on         (wall_on)
    );

    initial begin
        clk_50MHz = 1'b0;
        forever #10 clk_50MHz = ~clk_50MHz;
    end

    always @(posedge clk_50MHz) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_bit(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
            errors++;
        end
    endtask

    // Tank below the block touches none of its other sides
    task automatic check_other_sides(input string prefix, input int idx, input logic down,
                                     input logic left, input logic right);
        check_bit($sformatf("%sstop_down[%0d]", prefix, idx), down, 1'b0);
        check_bit($sformatf("%sstop_left[%0d]", prefix, idx), left, 1'b0);
        check_bit($sformatf("%sstop_right[%0d]", prefix, idx), right, 1'b0);
    endtask

    task automatic set_pixel(input int px, input int py);
        @(posedge clk_50MHz);
        x <= coord_t'(px);
        y <= coord_t'(py);
        @(negedge clk_50MHz);
    endtask

    task automatic set_tank(input logic enemy, input int l, input int r, input int t,
                            input int b);
        @(posedge clk_50MHz);
        if (enemy) begin
            enemy_l <= coord_t'(l);
            enemy_r <= coord_t'(r);
            enemy_t <= coord_t'(t);
            enemy_b <= coord_t'(b);
        end else begin
            tank_l <= coord_t'(l);
            tank_r <= coord_t'(r);
            tank_t <= coord_t'(t);
            tank_b <= coord_t'(b);
        end
        @(negedge clk_50MHz);
    endtask

    // The other bullet is parked in the corner, clear of every block
    task automatic fire(input logic player, input int bx, input int by, input logic tick);
        @(posedge clk_50MHz);
        if (player) begin
            bullet_x       <= coord_t'(bx);
            bullet_y       <= coord_t'(by);
            enemy_bullet_x <= '0;
            enemy_bullet_y <= '0;
        end else begin
            enemy_bullet_x <= coord_t'(bx);
            enemy_bullet_y <= coord_t'(by);
            bullet_x       <= '0;
            bullet_y       <= '0;
        end
        refresh_tick <= tick;
        @(posedge clk_50MHz);
        refresh_tick <= 1'b0;
        @(negedge clk_50MHz);
    endtask

    task automatic run_vector(input logic [63:0] op, input int a, input int b, input int c,
                              input int d, input int idx, input int expv, input int line_no);
        case (op)
            OP_WALL: begin
                set_pixel(a, b);
                check_bit("wall_on", wall_on, expv[0]);
            end
            OP_BRICK: begin
                set_pixel(a, b);
                check_bit($sformatf("brick_on[%0d]", idx), brick_on[idx], expv[0]);
            end
            OP_IRON: begin
                set_pixel(a, b);
                check_bit($sformatf("iron_on[%0d]", idx), iron_on[idx], expv[0]);
            end
            OP_UP: begin
                set_tank(1'b0, a, b, c, d);
                check_bit($sformatf("stop_up[%0d]", idx), stop_up[idx], expv[0]);
                check_other_sides("", idx, stop_down[idx], stop_left[idx],
                                  stop_right[idx]);
            end
            OP_EUP: begin
                set_tank(1'b1, a, b, c, d);
                check_bit($sformatf("enemy_stop_up[%0d]", idx), enemy_stop_up[idx], expv[0]);
                check_other_sides("enemy_", idx, enemy_stop_down[idx], enemy_stop_left[idx],
                                  enemy_stop_right[idx]);
            end
            OP_SHOT: begin
                fire(1'b1, a, b, c[0]);
                check_bit("hit", hit, expv[0]);
                check_bit("enemy_hit", enemy_hit, 1'b0);
            end
            OP_ESHOT: begin
                fire(1'b0, a, b, c[0]);
                check_bit("enemy_hit", enemy_hit, expv[0]);
                check_bit("hit", hit, 1'b0);
            end
            default: begin
                $display("Unknown operation on stimulus line %0d", line_no);
                errors++;
            end
        endcase
    endtask

    task automatic run_vectors(input int fd);
        string line;
        logic [63:0] op;
        int n;
        int a;
        int b;
        int c;
        int d;
        int idx;
        int expv;
        int line_no;
        int errors_before;
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %d %d %d %d %d %d", op, a, b, c, d, idx, expv);
                if (n != 7) begin
                    $display("Stimulus line %0d could not be parsed", line_no);
                    errors++;
                end else begin
                    errors_before = errors;
                    run_vector(op, a, b, c, d, idx, expv, line_no);
                    tests++;
                    $display("test %0d (stimulus line %0d): %s", tests, line_no,
                             errors == errors_before ? "pass" : "fail");
                end
            end
        end
    endtask

    initial begin
        int fd;
        reset          = 1'b1;
        x              = '0;
        y              = '0;
        refresh_tick   = 1'b0;
        tank_l         = '0;
        tank_r         = '0;
        tank_t         = '0;
        tank_b         = '0;
        enemy_l        = '0;
        enemy_r        = '0;
        enemy_t        = '0;
        enemy_b        = '0;
        bullet_x       = '0;
        bullet_y       = '0;
        enemy_bullet_x = '0;
        enemy_bullet_y = '0;
        fd = $fopen("bench/map_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/map_stimulus.txt");
            $display("Some tests failed");
            $finish;
        end else begin
            @(posedge clk_50MHz);
            reset <= 1'b0;
            repeat (4) @(posedge clk_50MHz);
            reset <= 1'b1;
            @(negedge clk_50MHz);
            run_vectors(fd);
            $fclose(fd);
            errors = errors + dut.u_map_chk.fail_count;
            $display("Tests run: %0d, errors: %0d, assertion failures: %0d",
                     tests, errors, dut.u_map_chk.fail_count);
            if (errors == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
            $finish;
        end
    end

endmodule

//--- bench/map_chk.sv
`timescale 1ns/100ps

module map_chk
    import map_pkg::*;
#(
    parameter int num_brick = 100
) (
    input logic                 clk_50MHz,
    input logic                 reset,
    input logic                 refresh_tick,
    input logic                 hit,
    input logic                 enemy_hit,
    input coord_t               x,
    input coord_t               y,
    input logic [num_brick-1:0] brick_on
);

    int fail_count = 0;

    // Hits only echo a tick from one cycle back
    hit_after_tick: assert property (@(posedge clk_50MHz) disable iff (!reset)
        hit |-> $past(refresh_tick))
        else begin
            fail_count++;
            $error("hit high without refresh_tick in the previous cycle");
        end

    enemy_hit_after_tick: assert property (@(posedge clk_50MHz) disable iff (!reset)
        enemy_hit |-> $past(refresh_tick))
        else begin
            fail_count++;
            $error("enemy_hit high without refresh_tick in the previous cycle");
        end

    hit_low_in_reset: assert property (@(posedge clk_50MHz)
        !reset |-> (!hit && !enemy_hit))
        else begin
            fail_count++;
            $error("hit or enemy_hit high during reset");
        end

    // Dead bricks stay dead
    brick_no_revive: assert property (@(posedge clk_50MHz) disable iff (!reset)
        ($stable(x) && $stable(y)) |-> ((brick_on & ~$past(brick_on)) == '0))
        else begin
            fail_count++;
            $error("brick_on rose at a constant pixel");
        end

endmodule

bind map_top map_chk #(
    .num_brick(num_brick)
) u_map_chk (
    .clk_50MHz   (clk_50MHz),
    .reset       (reset),
    .refresh_tick(refresh_tick),
    .hit         (hit),
    .enemy_hit   (enemy_hit),
    .x           (x),
    .y           (y),
    .brick_on    (brick_on)
);

//--- hw/map_top.sv
`timescale 1ns/100ps

module map_top
    import map_pkg::*;
#(
    parameter int num_brick          = 100,
    parameter int player_bullet_size = 4
) (
    input  logic                          clk_50MHz,
    input  logic                          reset,
    input  coord_t                        x,
    input  coord_t                        y,
    input  logic                          refresh_tick,
    input  coord_t                        tank_l,
    input  coord_t                        tank_r,
    input  coord_t                        tank_t,
    input  coord_t                        tank_b,
    input  coord_t                        enemy_l,
    input  coord_t                        enemy_r,
    input  coord_t                        enemy_t,
    input  coord_t                        enemy_b,
    input  coord_t                        bullet_x,
    input  coord_t                        bullet_y,
    input  coord_t                        enemy_bullet_x,
    input  coord_t                        enemy_bullet_y,
    output logic                          hit,
    output logic                          enemy_hit,
    output logic [num_brick+NUM_IRON-1:0] stop_up,
    output logic [num_brick+NUM_IRON-1:0] stop_down,
    output logic [num_brick+NUM_IRON-1:0] stop_left,
    output logic [num_brick+NUM_IRON-1:0] stop_right,
    output logic [num_brick+NUM_IRON-1:0] enemy_stop_up,
    output logic [num_brick+NUM_IRON-1:0] enemy_stop_down,
    output logic [num_brick+NUM_IRON-1:0] enemy_stop_left,
    output logic [num_brick+NUM_IRON-1:0] enemy_stop_right,
    output logic [num_brick-1:0]          brick_on,
    output logic [NUM_IRON-1:0]           iron_on,
    output logic                          wall_on
);

    localparam int ENEMY_BULLET_SIZE = 4;

    logic [num_brick-1:0] brick_alive;
    logic [num_brick-1:0] player_kill;
    logic [num_brick-1:0] enemy_kill;
    logic [num_brick-1:0] brick_kill;

    // Either bullet can break a brick
    assign brick_kill = player_kill | enemy_kill;

    brick_state #(
        .num_brick(num_brick)
    ) u_brick_state (
        .clk_50MHz  (clk_50MHz),
        .reset      (reset),
        .brick_kill (brick_kill),
        .brick_alive(brick_alive)
    );

    bullet_collide #(
        .num_brick  (num_brick),
        .bullet_size(player_bullet_size)
    ) u_player_bullet (
        .clk_50MHz   (clk_50MHz),
        .reset       (reset),
        .refresh_tick(refresh_tick),
        .bullet_x    (bullet_x),
        .bullet_y    (bullet_y),
        .brick_alive (brick_alive),
        .brick_kill  (player_kill),
        .hit         (hit)
    );

    bullet_collide #(
        .num_brick  (num_brick),
        .bullet_size(ENEMY_BULLET_SIZE)
    ) u_enemy_bullet (
        .clk_50MHz   (clk_50MHz),
        .reset       (reset),
        .refresh_tick(refresh_tick),
        .bullet_x    (enemy_bullet_x),
        .bullet_y    (enemy_bullet_y),
        .brick_alive (brick_alive),
        .brick_kill  (enemy_kill),
        .hit         (enemy_hit)
    );

    block_stop #(
        .num_brick(num_brick)
    ) u_player_stop (
        .tank_l     (tank_l),
        .tank_r     (tank_r),
        .tank_t     (tank_t),
        .tank_b     (tank_b),
        .brick_alive(brick_alive),
        .stop_up    (stop_up),
        .stop_down  (stop_down),
        .stop_left  (stop_left),
        .stop_right (stop_right)
    );

    block_stop #(
        .num_brick(num_brick)
    ) u_enemy_stop (
        .tank_l     (enemy_l),
        .tank_r     (enemy_r),
        .tank_t     (enemy_t),
        .tank_b     (enemy_b),
        .brick_alive(brick_alive),
        .stop_up    (enemy_stop_up),
        .stop_down  (enemy_stop_down),
        .stop_left  (enemy_stop_left),
        .stop_right (enemy_stop_right)
    );

    pixel_map #(
        .num_brick(num_brick)
    ) u_pixel_map (
        .x          (x),
        .y          (y),
        .brick_alive(brick_alive),
        .brick_on   (brick_on),
        .iron_on    (iron_on),
        .wall_on    (wall_on)
    );

endmodule

//--- hw/pixel_map.sv
`timescale 1ns/100ps

module pixel_map
    import map_pkg::*;
#(
    parameter int num_brick = 100
) (
    input  coord_t                 x,
    input  coord_t                 y,
    input  logic [num_brick-1:0]   brick_alive,
    output logic [num_brick-1:0]   brick_on,
    output logic [NUM_IRON-1:0]    iron_on,
    output logic                   wall_on
);

    localparam int NUM_BLOCK = num_brick + NUM_IRON;

    logic [NUM_BLOCK-1:0] live;
    logic [NUM_BLOCK-1:0] block_on;

    assign live = {{NUM_IRON{1'b1}}, brick_alive};

    for (genvar k = 0; k < NUM_BLOCK; k++) begin : g_block
        localparam block_t BLK = block_box(k, num_brick);

        // Box edges are inclusive
        assign block_on[k] = live[k]
                          && (x >= BLK.l) && (x <= BLK.r)
                          && (y >= BLK.t) && (y <= BLK.b);
    end

    assign brick_on = block_on[num_brick-1:0];
    assign iron_on  = block_on[NUM_BLOCK-1:num_brick];

    assign wall_on = !((x >= WALL_MIN_X) && (x <= WALL_MAX_X)
                    && (y >= WALL_MIN_Y) && (y <= WALL_MAX_Y));

endmodule

//--- hw/block_stop.sv
`timescale 1ns/100ps

module block_stop
    import map_pkg::*;
#(
    parameter int num_brick = 100
) (
    input  coord_t                          tank_l,
    input  coord_t                          tank_r,
    input  coord_t                          tank_t,
    input  coord_t                          tank_b,
    input  logic [num_brick-1:0]            brick_alive,
    output logic [num_brick+NUM_IRON-1:0]   stop_up,
    output logic [num_brick+NUM_IRON-1:0]   stop_down,
    output logic [num_brick+NUM_IRON-1:0]   stop_left,
    output logic [num_brick+NUM_IRON-1:0]   stop_right
);

    localparam int NUM_BLOCK = num_brick + NUM_IRON;

    logic [NUM_BLOCK-1:0] live;

    assign live = {{NUM_IRON{1'b1}}, brick_alive};

    for (genvar k = 0; k < NUM_BLOCK; k++) begin : g_block
        localparam block_t BLK = block_box(k, num_brick);

        // Tank edge positions that touch the block
        localparam coord_t EDGE_UP    = BLK.b + coord_t'(STOP_GAP);
        localparam coord_t EDGE_DOWN  = BLK.t - coord_t'(STOP_GAP);
        localparam coord_t EDGE_LEFT  = BLK.r + coord_t'(STOP_GAP);
        localparam coord_t EDGE_RIGHT = BLK.l - coord_t'(STOP_GAP);

        // Sideways window around the block
        localparam coord_t REACH_L = BLK.l - coord_t'(STOP_REACH);
        localparam coord_t REACH_R = BLK.r + coord_t'(STOP_REACH);
        localparam coord_t REACH_T = BLK.t - coord_t'(STOP_REACH);
        localparam coord_t REACH_B = BLK.b + coord_t'(STOP_REACH);

        logic in_x;
        logic in_y;

        assign in_x = (tank_r <= REACH_R) && (tank_l >= REACH_L);
        assign in_y = (tank_b <= REACH_B) && (tank_t >= REACH_T);

        assign stop_up[k]    = live[k] && (tank_t == EDGE_UP) && in_x;
        assign stop_down[k]  = live[k] && (tank_b == EDGE_DOWN) && in_x;
        assign stop_left[k]  = live[k] && (tank_l == EDGE_LEFT) && in_y;
        assign stop_right[k] = live[k] && (tank_r == EDGE_RIGHT) && in_y;
    end

endmodule

//--- hw/bullet_collide.sv
`timescale 1ns/100ps

module bullet_collide
    import map_pkg::*;
#(
    parameter int num_brick   = 100,
    parameter int bullet_size = 4
) (
    input  logic                 clk_50MHz,
    input  logic                 reset,
    input  logic                 refresh_tick,
    input  coord_t               bullet_x,
    input  coord_t               bullet_y,
    input  logic [num_brick-1:0] brick_alive,
    output logic [num_brick-1:0] brick_kill,
    output logic                 hit
);

    localparam int NUM_BLOCK = num_brick + NUM_IRON;
    localparam coord_t BULLET_EXT = coord_t'(bullet_size - 1);

    coord_t bullet_r;
    coord_t bullet_b;
    logic [NUM_BLOCK-1:0] live;
    logic [NUM_BLOCK-1:0] overlap;

    assign bullet_r = bullet_x + BULLET_EXT;
    assign bullet_b = bullet_y + BULLET_EXT;

    // Irons never die
    assign live = {{NUM_IRON{1'b1}}, brick_alive};

    for (genvar k = 0; k < NUM_BLOCK; k++) begin : g_block
        localparam block_t BLK = block_box(k, num_brick);

        assign overlap[k] = live[k]
                         && (bullet_y < BLK.b) && (bullet_b > BLK.t)
                         && (bullet_x < BLK.r) && (bullet_r > BLK.l);
    end

    assign brick_kill = refresh_tick ? overlap[num_brick-1:0] : '0;

    // One-cycle pulse after the tick
    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            hit <= 1'b0;
        end else begin
            hit <= refresh_tick && (|overlap);
        end
    end

endmodule

//--- hw/brick_state.sv
`timescale 1ns/100ps

module brick_state #(
    parameter int num_brick = 100
) (
    input  logic                 clk_50MHz,
    input  logic                 reset,
    input  logic [num_brick-1:0] brick_kill,
    output logic [num_brick-1:0] brick_alive
);

    // Bricks stay dead until the next reset
    always_ff @(posedge clk_50MHz or negedge reset) begin
        if (!reset) begin
            brick_alive <= '1;
        end else begin
            brick_alive <= brick_alive & ~brick_kill;
        end
    end

endmodule

//--- hw/map_pkg.sv
package map_pkg;

    typedef logic [9:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } brick_pos_t;

    typedef struct packed {
        coord_t l;
        coord_t r;
        coord_t t;
        coord_t b;
    } block_t;

    localparam int BRICK_SIZE = 16;
    localparam int IRON_SIZE  = 32;
    localparam int STOP_GAP   = 2;
    localparam int STOP_REACH = 32;

    // Open field, everything outside is wall
    localparam coord_t WALL_MIN_X = 10'd32;
    localparam coord_t WALL_MAX_X = 10'd607;
    localparam coord_t WALL_MIN_Y = 10'd32;
    localparam coord_t WALL_MAX_Y = 10'd447;

    localparam int NUM_IRON         = 9;
    localparam int NUM_EAGLE_BRICKS = 20;

    // Generated grid
    localparam coord_t GRID_START_X = 10'd32;
    localparam coord_t GRID_START_Y = 10'd96;
    localparam coord_t GRID_LIMIT_X = 10'd527;
    localparam coord_t GRID_ROW_STEP = 10'd64;
    localparam coord_t GRID_WRAP_ODD = 10'd368;
    localparam coord_t GRID_WRAP_EVEN = 10'd288;

    localparam coord_t IRON_Y = 10'd256;
    localparam coord_t IRON_X [NUM_IRON] = '{
        10'd128, 10'd160, 10'd192, 10'd288, 10'd320, 10'd352, 10'd448, 10'd480, 10'd512
    };

    // Base guard, six columns
    localparam coord_t EAGLE_X [NUM_EAGLE_BRICKS] = '{
        10'd288, 10'd288, 10'd288,
        10'd304, 10'd304, 10'd304, 10'd304,
        10'd320, 10'd320, 10'd320,
        10'd336, 10'd336, 10'd336,
        10'd352, 10'd352, 10'd352, 10'd352,
        10'd368, 10'd368, 10'd368
    };
    localparam coord_t EAGLE_Y [NUM_EAGLE_BRICKS] = '{
        10'd432, 10'd416, 10'd400,
        10'd432, 10'd416, 10'd400, 10'd384,
        10'd400, 10'd384, 10'd368,
        10'd400, 10'd384, 10'd368,
        10'd432, 10'd416, 10'd400, 10'd384,
        10'd432, 10'd416, 10'd400
    };

    function automatic brick_pos_t brick_pos(int idx);
        brick_pos_t pos;
        logic wrap_odd;
        if (idx < NUM_EAGLE_BRICKS) begin
            pos.x = EAGLE_X[idx];
            pos.y = EAGLE_Y[idx];
            return pos;
        end
        pos.x = GRID_START_X;
        pos.y = GRID_START_Y;
        wrap_odd = 1'b0;
        for (int k = NUM_EAGLE_BRICKS + 1; k <= idx; k++) begin
            if (pos.x + coord_t'(BRICK_SIZE) > GRID_LIMIT_X) begin
                // Rows alternate their start column
                wrap_odd = !wrap_odd;
                pos.y = pos.y + GRID_ROW_STEP;
                pos.x = wrap_odd ? GRID_WRAP_ODD : GRID_WRAP_EVEN;
            end else begin
                pos.x = pos.x + coord_t'(BRICK_SIZE);
            end
        end
        return pos;
    endfunction

    // Bricks first, then irons
    function automatic block_t block_box(int idx, int num_brick);
        brick_pos_t pos;
        int size;
        block_t box;
        if (idx < num_brick) begin
            pos = brick_pos(idx);
            size = BRICK_SIZE;
        end else begin
            pos.x = IRON_X[idx - num_brick];
            pos.y = IRON_Y;
            size = IRON_SIZE;
        end
        box.l = pos.x;
        box.r = pos.x + coord_t'(size - 1);
        box.t = pos.y;
        box.b = pos.y + coord_t'(size - 1);
        return box;
    endfunction

endpackage
